// ==== rtl/csa_calc_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module csa_calc_ctrl (
	input  wire                        clk,
	input  wire                        rst_n,

	input  wire                        req_valid,
	output logic                       req_ready,

	input  wire                        last_round,
	output logic                       load,
	output logic                       step,

	output logic                       rsp_valid,
	input  wire                        rsp_ready,
	input  wire [csa_pkg::out_w-1:0]   cb_low,
	output csa_pkg::calc_rsp_t         rsp
);

	import csa_pkg::*;

	calc_state_t state;
	calc_state_t state_nxt;
	logic        accept;
	logic        taken;
	logic        finish;

	assign req_ready = (state == st_idle);
	assign rsp_valid = (state == st_done);

	assign accept = req_valid && req_ready;
	assign taken  = rsp_valid && rsp_ready;
	assign finish = (state == st_run) && last_round;

	assign load = accept;                            // key 0 and count load together.
	assign step = (state == st_run) && !last_round;  // advance ck, final round is only sampled.

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: begin
				if (accept) begin
					state_nxt = st_run;
				end
			end
			st_run: begin
				if (last_round) begin
					state_nxt = st_done;
				end
			end
			st_done: begin
				if (taken) begin
					state_nxt = st_idle;
				end
			end
			default: begin
				state_nxt = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			state <= state_nxt;
		end
	end

	// result is held until the response is taken.
	always_ff @(posedge clk) begin
		if (finish) begin
			rsp.result <= cb_low;
		end
	end

	a_rsp_stable: assert property (
		@(posedge clk) disable iff (!rst_n)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp)
	) else $error("rsp changed while stalled");

endmodule

`default_nettype wire

// ==== rtl/csa_calc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module csa_calc_top #(
	parameter logic [csa_pkg::id_w-1:0] core_id = '0
) (
	input  wire                 clk,
	input  wire                 rst_n,

	input  wire                 req_valid,
	input  csa_pkg::calc_req_t  req,
	output logic                req_ready,

	output logic                rsp_valid,
	output csa_pkg::calc_rsp_t  rsp,
	input  wire                 rsp_ready
);

	import csa_pkg::*;

	logic               load;
	logic               step;
	logic               last_round;
	logic [times_w-1:0] loops;
	logic [seed_w-1:0]  seed_q;
	logic [seed_w-1:0]  seed_sel;
	key_t               ck;
	key_t               cb;
	key_t               next_key;

	// req may change once the job is accepted.
	always_ff @(posedge clk) begin
		if (load) begin
			seed_q <= req.seed;
		end
	end

	assign seed_sel = load ? req.seed : seed_q; // the accept edge already needs key 0.

	// working key, loaded on accept and advanced each round edge.
	always_ff @(posedge clk) begin
		if (load || step) begin
			ck <= next_key;
		end
	end

	csa_calc_ctrl i_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.last_round (last_round),
		.load       (load),
		.step       (step),
		.rsp_valid  (rsp_valid),
		.rsp_ready  (rsp_ready),
		.cb_low     (cb[out_w-1:0]),
		.rsp        (rsp)
	);

	iter_counter i_counter (
		.clk        (clk),
		.rst_n      (rst_n),
		.load       (load),
		.times      (req.times),
		.step       (step),
		.loops      (loops),
		.last_round (last_round)
	);

	key_stepper #(
		.core_id (core_id)
	) i_stepper (
		.seed     (seed_sel),
		.cb       (cb),
		.loops    (loops),
		.first    (load),
		.next_key (next_key)
	);

	stream_round i_round (
		.ck (ck),
		.cb (cb)
	);

endmodule

`default_nettype wire

// ==== rtl/csa_pkg.sv ====
`default_nettype none

package csa_pkg;

	localparam int key_w   = 64; // working key and cipher output.
	localparam int seed_w  = 40; // candidate seed from the requester.
	localparam int out_w   = 48; // low part of the last cipher output.
	localparam int times_w = 32; // iteration count and loop count.
	localparam int id_w    = 8;  // engine core id.

	// zero bits above the id in key 0.
	localparam int key_pad_w = key_w - id_w - seed_w;

	localparam int key_nibbles = key_w / 4;
	localparam int round_steps = 4;  // mixing steps per round.
	localparam int round_rot   = 13; // left rotation after each step.

	localparam logic [key_w-1:0] cipher_const = 64'he613_db6d_c11c_4524;

	// 4-bit permutation, entry 0 listed first.
	localparam logic [3:0] nibble_sbox [16] = '{
		4'hc, 4'h5, 4'h6, 4'hb,
		4'h9, 4'h0, 4'ha, 4'hd,
		4'h3, 4'he, 4'hf, 4'h8,
		4'h4, 4'h7, 4'h1, 4'h2
	};

	typedef logic [key_w-1:0] key_t;

	typedef struct packed {
		logic [times_w-1:0] times; // rounds to run, zero runs one.
		logic [seed_w-1:0]  seed;
	} calc_req_t;

	typedef struct packed {
		logic [out_w-1:0] result;
	} calc_rsp_t;

	typedef enum logic [1:0] {
		st_idle = 2'd0,
		st_run  = 2'd1,
		st_done = 2'd2
	} calc_state_t;

endpackage

`default_nettype wire

// ==== rtl/iter_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module iter_counter (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          load,
	input  wire [csa_pkg::times_w-1:0]   times,
	input  wire                          step,
	output logic [csa_pkg::times_w-1:0]  loops,
	output logic                         last_round
);

	import csa_pkg::*;

	logic [times_w-1:0] remain;
	logic [times_w-1:0] times_clamped;

	assign times_clamped = (times == '0) ? times_w'(1) : times; // zero runs one round.
	assign last_round    = (remain == times_w'(1));

	// rounds still to run, including the one under way.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			remain <= '0;
		end else if (load) begin
			remain <= times_clamped;
		end else if (step) begin
			remain <= remain - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			loops <= '0;
		end else if (load) begin
			loops <= '0;
		end else if (step) begin
			loops <= loops + 1'b1;
		end
	end

	a_step_loaded: assert property (
		@(posedge clk) disable iff (!rst_n)
		step |-> remain != '0
	) else $error("step with no rounds left");

endmodule

`default_nettype wire

// ==== rtl/key_stepper.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_stepper #(
	parameter logic [csa_pkg::id_w-1:0] core_id = '0
) (
	input  wire [csa_pkg::seed_w-1:0]   seed,
	input  wire [csa_pkg::key_w-1:0]    cb,
	input  wire [csa_pkg::times_w-1:0]  loops,
	input  wire                         first,
	output logic [csa_pkg::key_w-1:0]   next_key
);

	import csa_pkg::*;

	logic [key_w-1:0]   key_init;
	logic [key_w-1:0]   key_step;
	logic [times_w-1:0] loop_idx;

	// key 0 is zero pad, core id, seed.
	assign key_init = {{key_pad_w{1'b0}}, core_id, seed};

	// index of the key being formed.
	assign loop_idx = loops + 1'b1;

	// only the low word takes the loop index.
	assign key_step = {cb[key_w-1:times_w], cb[times_w-1:0] ^ loop_idx};

	assign next_key = first ? key_init : key_step;

endmodule

`default_nettype wire

// ==== rtl/stream_round.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_round (
	input  wire [csa_pkg::key_w-1:0]   ck,
	output logic [csa_pkg::key_w-1:0]  cb
);

	import csa_pkg::*;

	// every nibble goes through the same table.
	function automatic key_t sub_nibbles(input key_t v);
		key_t r;
		for (int n = 0; n < key_nibbles; n++) begin
			r[4*n +: 4] = nibble_sbox[v[4*n +: 4]];
		end
		return r;
	endfunction

	function automatic key_t rotl(input key_t v);
		key_t r;
		r = {v[key_w-1-round_rot:0], v[key_w-1:key_w-round_rot]};
		return r;
	endfunction

	key_t stage [round_steps+1];

	assign stage[0] = ck;

	for (genvar s = 0; s < round_steps; s++) begin : g_step
		key_t mixed;
		key_t subst;

		assign mixed        = stage[s] ^ cipher_const; // constant is fixed, not a port.
		assign subst        = sub_nibbles(mixed);
		assign stage[s + 1] = rotl(subst);
	end

	assign cb = stage[round_steps];

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator not found"
	exit 1
fi

if ! verilator --binary --assert --timing -f tb.f --top-module tb_csa_calc -Mdir obj_dir; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_csa_calc)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
	exit 0
fi

echo "simulation did not pass"
exit 1

// ==== tb.f ====
rtl/csa_pkg.sv
rtl/csa_calc_ctrl.sv
rtl/iter_counter.sv
rtl/key_stepper.sv
rtl/stream_round.sv
rtl/csa_calc_top.sv
tb/tb_csa_calc.sv

// ==== tb/csa_calc_patterns.txt ====
// one word per job: seed (10 hex digits), count (8), cycles from accept to rsp_valid (8).
// results follow from the key and round rules and are worked out in the testbench.
123456789a0000000100000001
123456789a0000000000000001
00000000000000000100000001
ffffffffff0000000200000002
a55ac33c0f0000000300000003
0badc0ffee0000001000000010
deadbeef010000000700000007
13579246800000004000000040
fedcba9876000003e8000003e8
c0ffee12340000010000000100
55aa55aa550000000000000001
01020304050000000500000005
77777777770000002100000021
80000000010000000400000004

// ==== tb/tb_csa_calc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_csa_calc;

	import csa_pkg::*;

	localparam logic [7:0]  dut_id      = 8'h5a;
	localparam logic [63:0] round_const = 64'he613_db6d_c11c_4524;
	localparam int          max_jobs    = 32;
	localparam int          stall_slack = 40; // cycles per job for gaps and stalls.

	typedef struct packed {
		logic [39:0] seed;
		logic [31:0] count;
		logic [31:0] latency; // cycles from accept edge to rsp_valid.
	} pattern_t;

	logic      clk = 1'b0;
	logic      rst_n;
	logic      req_valid;
	calc_req_t req;
	logic      req_ready;
	logic      rsp_valid;
	calc_rsp_t rsp;
	logic      rsp_ready;

	pattern_t    patterns [max_jobs];
	logic [47:0] results  [max_jobs];
	int          num_jobs;
	int          errors      = 0;
	int          cycle_count = 0;
	int          cycle_limit;

	csa_calc_top #(
		.core_id (dut_id)
	) i_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_valid (req_valid),
		.req       (req),
		.req_ready (req_ready),
		.rsp_valid (rsp_valid),
		.rsp       (rsp),
		.rsp_ready (rsp_ready)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("engine hung: the run did not finish within %0d cycles", cycle_limit);
			$display("TEST FAIL");
			$finish;
		end
	end

	function automatic logic [3:0] sbox_lookup(input logic [3:0] nib);
		logic [3:0] r;
		case (nib)
			4'h0: r = 4'hc;
			4'h1: r = 4'h5;
			4'h2: r = 4'h6;
			4'h3: r = 4'hb;
			4'h4: r = 4'h9;
			4'h5: r = 4'h0;
			4'h6: r = 4'ha;
			4'h7: r = 4'hd;
			4'h8: r = 4'h3;
			4'h9: r = 4'he;
			4'ha: r = 4'hf;
			4'hb: r = 4'h8;
			4'hc: r = 4'h4;
			4'hd: r = 4'h7;
			4'he: r = 4'h1;
			4'hf: r = 4'h2;
		endcase
		return r;
	endfunction

	// four steps of xor, nibble table and rotation.
	function automatic logic [63:0] round_ref(input logic [63:0] v);
		logic [63:0] x;
		logic [63:0] s;
		x = v;
		for (int k = 0; k < 4; k++) begin
			x = x ^ round_const;
			for (int n = 0; n < 16; n++) begin
				s[4*n +: 4] = sbox_lookup(x[4*n +: 4]);
			end
			x = {s[50:0], s[63:51]}; // rotate left by 13.
		end
		return x;
	endfunction

	function automatic logic [47:0] expected_result(input logic [39:0] seed,
		input logic [31:0] count);
		logic [63:0] key;
		logic [31:0] n;
		logic [31:0] i;
		n   = (count == 32'd0) ? 32'd1 : count;
		key = {16'h0000, dut_id, seed};
		for (i = 32'd1; i < n; i++) begin
			key = round_ref(key) ^ {32'h0, i};
		end
		key = round_ref(key);
		return key[47:0];
	endfunction

	task automatic run_job(input int idx, input bit back_to_back);
		logic [47:0] expected;
		logic [47:0] held;
		int          lat;
		int          stall;
		expected  = expected_result(patterns[idx].seed, patterns[idx].count);
		req_valid = 1'b1;
		req.times = patterns[idx].count;
		req.seed  = patterns[idx].seed;
		rsp_ready = back_to_back;
		while (!req_ready) begin
			@(negedge clk);
		end
		@(negedge clk); // accepted on the edge just passed.
		req_valid = 1'b0;
		req.times = $urandom;
		req.seed  = {8'($urandom), 32'($urandom)};
		lat = 0;
		while (!rsp_valid) begin
			if (req_ready) begin
				errors++;
				$display("Error at %0t: seed %h req_ready high during a run",
					$time, patterns[idx].seed);
			end
			@(negedge clk);
			lat++;
		end
		if (lat != int'(patterns[idx].latency)) begin
			errors++;
			$display("Error at %0t: seed %h expected %0d cycles to rsp_valid, got %0d",
				$time, patterns[idx].seed, patterns[idx].latency, lat);
		end
		if (rsp.result !== expected) begin
			errors++;
			$display("Error at %0t: seed %h expected %h got %h",
				$time, patterns[idx].seed, expected, rsp.result);
		end
		results[idx] = rsp.result;
		if (back_to_back) begin
			if (idx + 1 < num_jobs) begin // next job waits while this one is taken.
				req_valid = 1'b1;
				req.times = patterns[idx + 1].count;
				req.seed  = patterns[idx + 1].seed;
			end
		end else begin
			stall = $urandom_range(6, 0);
			held  = rsp.result;
			repeat (stall) begin
				@(negedge clk);
				if (!rsp_valid || rsp.result !== held || req_ready) begin
					errors++;
					$display("Error at %0t: seed %h expected %h held, got %h valid %b ready %b",
						$time, patterns[idx].seed, held, rsp.result, rsp_valid, req_ready);
				end
			end
			rsp_ready = 1'b1;
			@(negedge clk);
			rsp_ready = 1'b0;
			if (rsp_valid || !req_ready) begin
				errors++;
				$display("Error at %0t: seed %h engine not idle after the response was taken",
					$time, patterns[idx].seed);
			end
		end
	endtask

	initial begin
		int unsigned seed_init;
		seed_init = $urandom(32'heafc_0c77);
		rst_n     = 1'b0;
		req_valid = 1'b0;
		req       = '0;
		rsp_ready = 1'b0;
		for (int i = 0; i < max_jobs; i++) begin
			patterns[i] = '0;
		end
		$readmemh("tb/csa_calc_patterns.txt", patterns);
		num_jobs = 0;
		// a job takes at least one cycle, unused entries stay at zero latency.
		while (num_jobs < max_jobs && patterns[num_jobs].latency != 32'd0) begin
			num_jobs++;
		end
		if (num_jobs == 0) begin
			errors++;
			$display("no patterns were read from tb/csa_calc_patterns.txt");
		end
		cycle_limit = 100 + stall_slack * num_jobs;
		for (int i = 0; i < num_jobs; i++) begin
			cycle_limit += (patterns[i].count == 32'd0) ? 1 : int'(patterns[i].count);
		end

		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		if (!req_ready || rsp_valid) begin
			errors++;
			$display("Error at %0t: after reset req_ready %b rsp_valid %b",
				$time, req_ready, rsp_valid);
		end

		// first half paced with gaps and stalls, second half back to back.
		for (int j = 0; j < num_jobs; j++) begin
			if (j < num_jobs / 2) begin
				repeat ($urandom_range(3, 0)) @(negedge clk);
				run_job(j, 1'b0);
			end else begin
				run_job(j, 1'b1);
			end
		end
		@(negedge clk);
		rsp_ready = 1'b0;
		if (rsp_valid) begin
			errors++;
			$display("Error at %0t: last response was not taken", $time);
		end

		for (int i = 0; i < num_jobs; i++) begin
			for (int k = 0; k < num_jobs; k++) begin
				if (patterns[i].count == 32'd0 && patterns[k].count == 32'd1 &&
					patterns[i].seed == patterns[k].seed && results[i] !== results[k]) begin
					errors++;
					$display("Error at %0t: seed %h expected %h for count 0, got %h",
						$time, patterns[i].seed, results[k], results[i]);
				end
			end
		end

		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
